// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_eye_tracker
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "Simulation ended without status"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim.f ====
source/eye_pkg.sv
source/pix_if.sv
source/sums_if.sv
source/camera_input.sv
source/centroid_accum.sv
source/centroid_divider.sv
source/result_sender.sv
source/eye_tracker_top.sv
tests/eye_tracker_asserts.sv
tests/tb_eye_tracker.sv

// ==== source/camera_input.sv ====
// --------------------------------------------------------------------------
// Camera Link style input stage. Registers the two taps and the framing
// signals, tracks column and row, thresholds both pixels and flags the
// end of each frame on pix_if.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module camera_input (
    input  logic            cclk,
    input  logic            rst_n,
    input  logic            fval,
    input  logic            lval,
    input  logic            dval,
    input  eye_pkg::pixel_t data_l,
    input  eye_pkg::pixel_t data_r,
    input  eye_pkg::pixel_t threshold,
    pix_if.src              pix
);

    logic            fval_q, lval_q, dval_q;
    logic            fval_d, lval_d;
    eye_pkg::pixel_t data_l_q, data_r_q;
    eye_pkg::coord_t x_cnt, y_cnt;
    logic            beat;
    logic            lval_fall;

    // fval and lval active high, dval active low
    assign beat      = fval_q & lval_q & ~dval_q;
    assign lval_fall = lval_d & ~lval_q;

    // --------------------------------------------------------------------------
    // Input registers and edge history
    // --------------------------------------------------------------------------
    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            fval_q <= 1'b0;
            lval_q <= 1'b0;
            dval_q <= 1'b1;
            fval_d <= 1'b0;
            lval_d <= 1'b0;
        end else begin
            fval_q <= fval;
            lval_q <= lval;
            dval_q <= dval;
            fval_d <= fval_q;
            lval_d <= lval_q;
        end
    end

    always_ff @(posedge cclk) begin
        data_l_q <= data_l;
        data_r_q <= data_r;
    end

    // --------------------------------------------------------------------------
    // Column and row counters
    // --------------------------------------------------------------------------
    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else begin
            // Column restarts between lines
            if (!lval_q) begin
                x_cnt <= '0;
            end else if (beat) begin
                x_cnt <= x_cnt + eye_pkg::coord_t'(eye_pkg::TAPS);
            end
            // Row restarts between frames, steps at each line end
            if (!fval_q) begin
                y_cnt <= '0;
            end else if (lval_fall) begin
                y_cnt <= y_cnt + 1'b1;
            end
        end
    end

    // --------------------------------------------------------------------------
    // Output beat
    // --------------------------------------------------------------------------
    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            pix.valid     <= 1'b0;
            pix.frame_end <= 1'b0;
        end else begin
            pix.valid     <= beat;
            pix.frame_end <= fval_d & ~fval_q;
        end
    end

    // Strictly greater than the threshold counts as a hit
    always_ff @(posedge cclk) begin
        pix.x     <= x_cnt;
        pix.y     <= y_cnt;
        pix.hit_l <= (data_l_q > threshold);
        pix.hit_r <= (data_r_q > threshold);
    end

endmodule

// ==== source/centroid_accum.sv ====
// --------------------------------------------------------------------------
// Frame accumulator. Sums the hit count and the x and y coordinates of
// every hit, then publishes S, SX and SY on sums_if at frame end.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module centroid_accum (
    input  logic cclk,
    input  logic rst_n,
    pix_if.dst   pix,
    sums_if.src  sums
);

    eye_pkg::sum_s_t  acc_s;
    eye_pkg::sum_xy_t acc_sx, acc_sy;
    eye_pkg::sum_s_t  add_s;
    eye_pkg::sum_xy_t add_sx, add_sy;
    eye_pkg::sum_xy_t x_l, x_r, y_ext;

    // Right tap sits one column past the left tap
    assign x_l   = eye_pkg::sum_xy_t'(pix.x);
    assign x_r   = x_l + eye_pkg::sum_xy_t'(1);
    assign y_ext = eye_pkg::sum_xy_t'(pix.y);

    assign add_s  = eye_pkg::sum_s_t'(pix.hit_l) + eye_pkg::sum_s_t'(pix.hit_r);
    assign add_sx = (pix.hit_l ? x_l : '0) + (pix.hit_r ? x_r : '0);
    assign add_sy = (pix.hit_l ? y_ext : '0) + (pix.hit_r ? y_ext : '0);

    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            acc_s      <= '0;
            acc_sx     <= '0;
            acc_sy     <= '0;
            sums.valid <= 1'b0;
        end else begin
            sums.valid <= pix.frame_end;
            // A valid beat never coincides with frame_end
            if (pix.frame_end) begin
                acc_s  <= '0;
                acc_sx <= '0;
                acc_sy <= '0;
            end else if (pix.valid) begin
                acc_s  <= acc_s + add_s;
                acc_sx <= acc_sx + add_sx;
                acc_sy <= acc_sy + add_sy;
            end
        end
    end

    // Published totals hold until the next frame end
    always_ff @(posedge cclk) begin
        if (pix.frame_end) begin
            sums.s  <= acc_s;
            sums.sx <= acc_sx;
            sums.sy <= acc_sy;
        end
    end

endmodule

// ==== source/centroid_divider.sv ====
// --------------------------------------------------------------------------
// Centroid divider. Two restoring dividers run side by side, one quotient
// bit per cycle, to give SX/S and SY/S rounded down. A result leaves on
// res_push 30 cycles after the sums arrive.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module centroid_divider (
    input  logic            cclk,
    input  logic            rst_n,
    sums_if.dst             sums,
    output logic            res_push,
    output logic            found,
    output eye_pkg::coord_t x,
    output eye_pkg::coord_t y
);

    localparam int S_W   = $bits(eye_pkg::sum_s_t);
    localparam int Q_W   = $bits(eye_pkg::sum_xy_t);
    localparam int C_W   = $bits(eye_pkg::coord_t);
    localparam int CNT_W = $clog2(Q_W);

    typedef enum logic [1:0] {st_idle, st_divide, st_finish} state_t;

    state_t           state;
    logic [CNT_W-1:0] bit_cnt;
    eye_pkg::sum_s_t  divisor;
    eye_pkg::sum_s_t  rem_x, rem_y, rem_x_nxt, rem_y_nxt;
    eye_pkg::sum_xy_t quo_x, quo_y, quo_x_nxt, quo_y_nxt;
    logic             any_hit;

    // One restoring step, dividend shifted in MSB first
    function automatic void div_step(
        input  eye_pkg::sum_s_t  rem_in,
        input  eye_pkg::sum_xy_t quo_in,
        input  eye_pkg::sum_s_t  d,
        output eye_pkg::sum_s_t  rem_out,
        output eye_pkg::sum_xy_t quo_out
    );
        logic [S_W:0] trial;
        logic [S_W:0] diff;
        trial = {rem_in, quo_in[Q_W-1]};
        diff  = trial - {1'b0, d};
        if (trial >= {1'b0, d}) begin
            rem_out = diff[S_W-1:0];
            quo_out = {quo_in[Q_W-2:0], 1'b1};
        end else begin
            rem_out = trial[S_W-1:0];
            quo_out = {quo_in[Q_W-2:0], 1'b0};
        end
    endfunction

    always_comb begin
        div_step(rem_x, quo_x, divisor, rem_x_nxt, quo_x_nxt);
        div_step(rem_y, quo_y, divisor, rem_y_nxt, quo_y_nxt);
    end

    assign any_hit = (divisor != '0);

    // --------------------------------------------------------------------------
    // FSM, load then 28 steps then finish
    // --------------------------------------------------------------------------
    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            bit_cnt  <= '0;
            res_push <= 1'b0;
        end else begin
            res_push <= 1'b0;
            case (state)
                st_idle: begin
                    if (sums.valid) begin
                        bit_cnt <= '0;
                        state   <= st_divide;
                    end
                end
                st_divide: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(Q_W - 1)) begin
                        state <= st_finish;
                    end
                end
                st_finish: begin
                    res_push <= 1'b1;
                    state    <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge cclk) begin
        if (state == st_idle && sums.valid) begin
            divisor <= sums.s;
            quo_x   <= sums.sx;
            quo_y   <= sums.sy;
            rem_x   <= '0;
            rem_y   <= '0;
        end else if (state == st_divide) begin
            rem_x <= rem_x_nxt;
            rem_y <= rem_y_nxt;
            quo_x <= quo_x_nxt;
            quo_y <= quo_y_nxt;
        end
        // Empty frame reports not found at the origin
        if (state == st_finish) begin
            found <= any_hit;
            x     <= any_hit ? quo_x[C_W-1:0] : '0;
            y     <= any_hit ? quo_y[C_W-1:0] : '0;
        end
    end

endmodule

// ==== source/eye_pkg.sv ====
// --------------------------------------------------------------------------
// Shared widths and constants for the eye-tracking centroid core.
// RTL files refer to these by scoped names.
// --------------------------------------------------------------------------

package eye_pkg;

    // --------------------------------------------------------------------------
    // Data widths
    // --------------------------------------------------------------------------

    // One camera pixel value
    typedef logic [7:0]  pixel_t;

    // Pixel column or row index
    typedef logic [9:0]  coord_t;

    // Per-frame hit count S
    typedef logic [19:0] sum_s_t;

    // Per-frame coordinate sum SX or SY
    typedef logic [27:0] sum_xy_t;

    // --------------------------------------------------------------------------
    // Camera format
    // --------------------------------------------------------------------------

    // Pixels per clock, left and right tap
    localparam int TAPS = 2;

endpackage

// ==== source/eye_tracker_top.sv ====
// --------------------------------------------------------------------------
// Eye-tracking centroid core. Camera pixels in, pupil centroid results
// out under credit flow control, all on the camera clock.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module eye_tracker_top #(
    parameter int CREDITS      = 2,
    parameter int RESULT_DEPTH = 4
) (
    input  logic            cclk,
    input  logic            rst_n,
    input  logic            fval,
    input  logic            lval,
    input  logic            dval,
    input  eye_pkg::pixel_t data_l,
    input  eye_pkg::pixel_t data_r,
    input  eye_pkg::pixel_t threshold,
    input  logic            res_credit,
    output logic            res_valid,
    output logic            res_found,
    output eye_pkg::coord_t res_x,
    output eye_pkg::coord_t res_y,
    output logic [7:0]      drop_count
);

    logic            div_push;
    logic            div_found;
    eye_pkg::coord_t div_x;
    eye_pkg::coord_t div_y;

    pix_if  i_pix ();
    sums_if i_sums ();

    // --------------------------------------------------------------------------
    // Input side
    // --------------------------------------------------------------------------
    camera_input i_camera_input (
        .cclk      (cclk),
        .rst_n     (rst_n),
        .fval      (fval),
        .lval      (lval),
        .dval      (dval),
        .data_l    (data_l),
        .data_r    (data_r),
        .threshold (threshold),
        .pix       (i_pix)
    );

    // --------------------------------------------------------------------------
    // Processing
    // --------------------------------------------------------------------------
    centroid_accum i_centroid_accum (
        .cclk  (cclk),
        .rst_n (rst_n),
        .pix   (i_pix),
        .sums  (i_sums)
    );

    centroid_divider i_centroid_divider (
        .cclk     (cclk),
        .rst_n    (rst_n),
        .sums     (i_sums),
        .res_push (div_push),
        .found    (div_found),
        .x        (div_x),
        .y        (div_y)
    );

    // --------------------------------------------------------------------------
    // Output side
    // --------------------------------------------------------------------------
    result_sender #(
        .CREDITS      (CREDITS),
        .RESULT_DEPTH (RESULT_DEPTH)
    ) i_result_sender (
        .cclk       (cclk),
        .rst_n      (rst_n),
        .res_push   (div_push),
        .found      (div_found),
        .x          (div_x),
        .y          (div_y),
        .res_credit (res_credit),
        .res_valid  (res_valid),
        .res_found  (res_found),
        .res_x      (res_x),
        .res_y      (res_y),
        .drop_count (drop_count)
    );

endmodule

// ==== source/pix_if.sv ====
// --------------------------------------------------------------------------
// Gated and thresholded pixel pairs, camera input to accumulator.
// No back-pressure, every beat is taken.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

interface pix_if;

    logic            valid;
    eye_pkg::coord_t x;
    eye_pkg::coord_t y;
    logic            hit_l;
    logic            hit_r;
    logic            frame_end;

    modport src (output valid, x, y, hit_l, hit_r, frame_end);

    modport dst (input valid, x, y, hit_l, hit_r, frame_end);

endinterface

// ==== source/result_sender.sv ====
// --------------------------------------------------------------------------
// Result queue with credit-based output. A result goes out on res_valid
// only while a credit is held; the rest wait in order, and arrivals to a
// full queue are dropped and counted.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module result_sender #(
    parameter int CREDITS      = 2,
    parameter int RESULT_DEPTH = 4
) (
    input  logic            cclk,
    input  logic            rst_n,
    input  logic            res_push,
    input  logic            found,
    input  eye_pkg::coord_t x,
    input  eye_pkg::coord_t y,
    input  logic            res_credit,
    output logic            res_valid,
    output logic            res_found,
    output eye_pkg::coord_t res_x,
    output eye_pkg::coord_t res_y,
    output logic [7:0]      drop_count
);

    localparam int C_W     = $bits(eye_pkg::coord_t);
    localparam int ENTRY_W = 1 + 2 * C_W;
    localparam int PTR_W   = (RESULT_DEPTH > 1) ? $clog2(RESULT_DEPTH) : 1;
    localparam int CNT_W   = $clog2(RESULT_DEPTH + 1);
    localparam int CRD_W   = $clog2(CREDITS + 1);

    logic [ENTRY_W-1:0] mem [RESULT_DEPTH];
    logic [PTR_W-1:0]   wr_ptr, rd_ptr;
    logic [CNT_W-1:0]   count;
    logic [CRD_W-1:0]   credits;
    logic [ENTRY_W-1:0] in_entry, head;
    logic               empty, full, send, pop, bypass, wr_en, drop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(RESULT_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_entry = {found, x, y};
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(RESULT_DEPTH));
    assign head     = empty ? in_entry : mem[rd_ptr];

    // Gap after each send keeps res_valid a single-cycle pulse
    assign send   = (!empty || res_push) && (credits != '0) && !res_valid;
    assign pop    = send && !empty;
    // Empty queue with a credit sends the new result straight away
    assign bypass = send && empty;
    assign wr_en  = res_push && !bypass && (!full || pop);
    assign drop   = res_push && full && !pop;

    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credits    <= CRD_W'(CREDITS);
            drop_count <= '0;
            res_valid  <= 1'b0;
        end else begin
            res_valid <= send;
            credits   <= credits + CRD_W'(res_credit) - CRD_W'(send);
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (wr_en && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !wr_en) begin
                count <= count - 1'b1;
            end
            // Saturating drop counter
            if (drop && drop_count != 8'hff) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    always_ff @(posedge cclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_entry;
        end
        if (send) begin
            {res_found, res_x, res_y} <= head;
        end
    end

endmodule

// ==== source/sums_if.sv ====
// --------------------------------------------------------------------------
// Per-frame S, SX and SY from the accumulator to the divider.
// The sums hold until the next valid pulse.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

interface sums_if;

    logic             valid;
    eye_pkg::sum_s_t  s;
    eye_pkg::sum_xy_t sx;
    eye_pkg::sum_xy_t sy;

    modport src (output valid, s, sx, sy);

    modport dst (input valid, s, sx, sy);

endinterface

// ==== tests/eye_tracker_asserts.sv ====
// --------------------------------------------------------------------------
// Protocol assertions for the credit based result output, bound into the
// result sender. Credits are tracked from the port side, res_credit in and
// res_valid out, independent of the sender's own counter.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module eye_tracker_asserts #(
    parameter int CREDITS = 2
) (
    input logic       cclk,
    input logic       rst_n,
    input logic       res_valid,
    input logic       res_credit,
    input logic [7:0] drop_count
);

    // Credits granted by the receiver and not yet spent on a send
    int granted;

    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            granted <= CREDITS;
        end else begin
            granted <= granted + int'(res_credit) - int'(res_valid);
        end
    end

    // Every send needs a credit returned before it
    a_credit_held: assert property (@(posedge cclk) disable iff (!rst_n)
        res_valid |-> granted > 0)
        else $error("res_valid was sent while no credit was held");

    a_single_cycle: assert property (@(posedge cclk) disable iff (!rst_n)
        res_valid |=> !res_valid)
        else $error("res_valid stayed high for more than one cycle");

    // Saturating counter, never wraps back
    a_drop_monotonic: assert property (@(posedge cclk) disable iff (!rst_n)
        drop_count >= $past(drop_count))
        else $error("drop_count decreased");

endmodule

bind result_sender eye_tracker_asserts #(
    .CREDITS (CREDITS)
) i_asserts (
    .cclk       (cclk),
    .rst_n      (rst_n),
    .res_valid  (res_valid),
    .res_credit (res_credit),
    .drop_count (drop_count)
);

// ==== tests/tb_eye_tracker.sv ====
// --------------------------------------------------------------------------
// Directed testbench for the eye-tracking centroid core. Frames are driven
// from an image array, the centroid is modelled from the same array and
// the credit based result stream is checked in order.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_eye_tracker;

    localparam int PERIOD       = 4;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_W        = 16;
    localparam int MAX_H        = 8;
    localparam int GAP          = 3;
    localparam int TAIL         = 4;
    localparam int LAT_CYCLES   = 33;
    localparam int NUM_FRAMES   = 17;
    localparam int NUM_TESTS    = 6;
    // Longest frame, one dval stall per line included
    localparam int FRAME_CYCLES = 2 + MAX_H * (MAX_W / 2 + 1 + GAP) + TAIL;
    localparam int TIMEOUT      = RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES + NUM_TESTS * 200;

    logic            cclk;
    logic            rst_n;
    logic            fval, lval, dval;
    eye_pkg::pixel_t data_l, data_r, threshold;
    logic            res_credit = 1'b0;
    logic            res_valid, res_found;
    eye_pkg::coord_t res_x, res_y;
    logic [7:0]      drop_count;

    eye_pkg::pixel_t img [MAX_W * MAX_H];
    logic [20:0]     exp_q[$];
    logic [20:0]     got_q[$];
    time             got_t[$];
    time             fall_time;
    logic            auto_credit;
    logic            manual_credit;
    logic [31:0]     lcg_state = 32'd49;
    int              errors = 0;
    int              checks = 0;
    int              cycles;

    eye_tracker_top #(
        .CREDITS      (2),
        .RESULT_DEPTH (4)
    ) i_dut (
        .cclk       (cclk),
        .rst_n      (rst_n),
        .fval       (fval),
        .lval       (lval),
        .dval       (dval),
        .data_l     (data_l),
        .data_r     (data_r),
        .threshold  (threshold),
        .res_credit (res_credit),
        .res_valid  (res_valid),
        .res_found  (res_found),
        .res_x      (res_x),
        .res_y      (res_y),
        .drop_count (drop_count)
    );

    initial begin
        cclk = 1'b0;
        forever #(PERIOD / 2) cclk = ~cclk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge cclk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("STATUS: FAIL");
        $finish;
    end

    // --------------------------------------------------------------------------
    // Result monitor, takes every result and returns credits
    // --------------------------------------------------------------------------
    always @(posedge cclk) begin
        if (rst_n && res_valid) begin
            got_q.push_back({res_found, res_x, res_y});
            got_t.push_back($time);
        end
        res_credit <= (auto_credit && res_valid) || manual_credit;
    end

    function automatic eye_pkg::pixel_t lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // Centroid model, hit means strictly above threshold, x and y round down
    function automatic logic [20:0] expected_centroid(input int w, input int h,
                                                      input eye_pkg::pixel_t thr);
        longint s, sx, sy;
        s  = 0;
        sx = 0;
        sy = 0;
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) begin
                if (img[r * MAX_W + c] > thr) begin
                    s++;
                    sx += c;
                    sy += r;
                end
            end
        end
        if (s == 0) begin
            return '0;
        end
        return {1'b1, eye_pkg::coord_t'(sx / s), eye_pkg::coord_t'(sy / s)};
    endfunction

    task automatic report_err(input string name, input longint exp, input longint got);
        errors++;
        $display("ERR %0t %s expected %0d got %0d", $time, name, exp, got);
    endtask

    task automatic fill_image(input eye_pkg::pixel_t v);
        for (int i = 0; i < MAX_W * MAX_H; i++) begin
            img[i] = v;
        end
    endtask

    task automatic paint_block(input int c0, input int c1, input int r0, input int r1,
                               input eye_pkg::pixel_t v);
        for (int r = r0; r <= r1; r++) begin
            for (int c = c0; c <= c1; c++) begin
                img[r * MAX_W + c] = v;
            end
        end
    endtask

    // --------------------------------------------------------------------------
    // Frame driver, noise adds bright pixels that must not count
    // --------------------------------------------------------------------------
    task automatic send_frame(input int w, input int h, input bit noise);
        @(posedge cclk);
        fval <= 1'b1;
        for (int r = 0; r < h; r++) begin
            for (int b = 0; b < w / eye_pkg::TAPS; b++) begin
                @(posedge cclk);
                lval   <= 1'b1;
                dval   <= 1'b0;
                data_l <= img[r * MAX_W + b * eye_pkg::TAPS];
                data_r <= img[r * MAX_W + b * eye_pkg::TAPS + 1];
                // Stalled beat inside the line
                if (noise && b == 0) begin
                    @(posedge cclk);
                    dval   <= 1'b1;
                    data_l <= 8'hff;
                    data_r <= 8'hff;
                end
            end
            // Line gap, with noise dval stays low while lval is low
            repeat (GAP) begin
                @(posedge cclk);
                lval   <= 1'b0;
                dval   <= !noise;
                data_l <= noise ? 8'hff : 8'h00;
                data_r <= noise ? 8'hff : 8'h00;
            end
        end
        @(posedge cclk);
        fval <= 1'b0;
        dval <= 1'b1;
        fall_time = $time;
        exp_q.push_back(expected_centroid(w, h, threshold));
        repeat (TAIL) @(posedge cclk);
    endtask

    task automatic wait_results(input int n);
        while (got_q.size() < n) begin
            @(posedge cclk);
        end
    endtask

    // res_credit high for n cycles, then crediting goes back to the monitor
    task automatic return_credits(input int n, input logic resume_auto);
        repeat (n) begin
            @(posedge cclk);
            manual_credit <= 1'b1;
        end
        @(posedge cclk);
        manual_credit <= 1'b0;
        auto_credit   <= resume_auto;
    endtask

    task automatic compare_results();
        logic [20:0] e;
        logic [20:0] g;
        checks++;
        if (got_q.size() != exp_q.size()) begin
            report_err("result count", exp_q.size(), got_q.size());
        end
        while (exp_q.size() > 0 && got_q.size() > 0) begin
            e = exp_q.pop_front();
            g = got_q.pop_front();
            checks += 3;
            if (g[20] !== e[20]) report_err("res_found", e[20], g[20]);
            if (g[19:10] !== e[19:10]) report_err("res_x", e[19:10], g[19:10]);
            if (g[9:0] !== e[9:0]) report_err("res_y", e[9:0], g[9:0]);
        end
        exp_q.delete();
        got_q.delete();
        got_t.delete();
    endtask

    // --------------------------------------------------------------------------
    // Tests
    // --------------------------------------------------------------------------
    task automatic test_single_block();
        time lat;
        @(posedge cclk);
        threshold <= 8'd128;
        fill_image(8'd20);
        paint_block(3, 6, 2, 4, 8'd200);
        send_frame(8, 6, 1'b0);
        wait_results(1);
        // Drive edge, sampling edge, 33 cycles, then the monitor edge
        lat = got_t[0] - fall_time;
        checks++;
        if (lat != (LAT_CYCLES + 2) * PERIOD) begin
            report_err("res_valid latency ns", (LAT_CYCLES + 2) * PERIOD, lat);
        end
        compare_results();
    endtask

    task automatic test_empty_frame();
        @(posedge cclk);
        threshold <= 8'd100;
        for (int i = 0; i < MAX_W * MAX_H; i++) begin
            img[i] = eye_pkg::pixel_t'(i % 101);
        end
        send_frame(8, 6, 1'b0);
        wait_results(1);
        checks++;
        if (got_q[0] !== 21'd0) report_err("res_found,res_x,res_y", 0, got_q[0]);
        compare_results();
    endtask

    task automatic test_threshold_gating();
        @(posedge cclk);
        threshold <= 8'd100;
        fill_image(8'd10);
        // Equal to threshold, not a hit
        paint_block(0, 7, 0, 0, 8'd100);
        paint_block(2, 3, 3, 4, 8'd150);
        send_frame(8, 6, 1'b1);
        wait_results(1);
        compare_results();
    endtask

    task automatic test_credit_wait();
        @(posedge cclk);
        threshold   <= 8'd128;
        auto_credit <= 1'b0;
        for (int k = 0; k < 3; k++) begin
            fill_image(8'd0);
            paint_block(k, k + 1, 1, 3, 8'd255);
            send_frame(8, 6, 1'b0);
        end
        wait_results(2);
        repeat (60) @(posedge cclk);
        checks++;
        if (got_q.size() != 2) report_err("results sent without credit", 2, got_q.size());
        return_credits(1, 1'b0);
        wait_results(3);
        compare_results();
        return_credits(2, 1'b1);
    endtask

    task automatic test_queue_overflow();
        @(posedge cclk);
        auto_credit <= 1'b0;
        for (int k = 0; k < 7; k++) begin
            fill_image(8'd0);
            paint_block(k, k + 1, 2, 4, 8'd255);
            send_frame(8, 6, 1'b0);
        end
        // Seventh result finds the queue full
        void'(exp_q.pop_back());
        wait_results(2);
        repeat (60) @(posedge cclk);
        checks += 2;
        if (got_q.size() != 2) report_err("results sent without credit", 2, got_q.size());
        if (drop_count !== 8'd1) report_err("drop_count", 1, drop_count);
        return_credits(2, 1'b1);
        wait_results(6);
        compare_results();
    endtask

    task automatic test_random_frames();
        @(posedge cclk);
        threshold <= 8'd200;
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < MAX_W * MAX_H; i++) begin
                img[i] = lcg_byte();
            end
            send_frame(MAX_W, MAX_H, 1'b0);
        end
        wait_results(4);
        compare_results();
    endtask

    initial begin
        rst_n         = 1'b0;
        fval          = 1'b0;
        lval          = 1'b0;
        dval          = 1'b1;
        data_l        = '0;
        data_r        = '0;
        threshold     = '0;
        auto_credit   = 1'b1;
        manual_credit = 1'b0;
        fall_time     = 0;
        repeat (RESET_CYCLES) @(posedge cclk);
        rst_n <= 1'b1;
        @(posedge cclk);
        checks += 2;
        if (res_valid !== 1'b0) report_err("res_valid", 0, res_valid);
        if (drop_count !== 8'd0) report_err("drop_count", 0, drop_count);
        test_single_block();
        test_empty_frame();
        test_threshold_gating();
        test_credit_wait();
        test_queue_overflow();
        test_random_frames();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
